/* hdl/pcm_pkg.sv */
// shared types for the pcm2ch sample player, referenced by scoped name from each block
package pcm_pkg;

    // host register map, one byte each
    typedef enum logic [3:0] {
        CHA_PRE_LO   = 4'd0,
        CHA_PRE_HI   = 4'd1,
        CHA_ADDR_LO  = 4'd2,
        CHA_ADDR_MID = 4'd3,
        CHA_ADDR_HI  = 4'd4,
        CHA_PLAY     = 4'd5,
        CHB_PRE_LO   = 4'd6,
        CHB_PRE_HI   = 4'd7,
        CHB_ADDR_LO  = 4'd8,
        CHB_ADDR_MID = 4'd9,
        CHB_ADDR_HI  = 4'd10,
        CHB_PLAY     = 4'd11,
        GAIN         = 4'd12,
        LOOP         = 4'd13
    } reg_idx_e;

    // prescaler length select, bit 0 set always means the low byte
    typedef enum logic [1:0] {
        FULL12   = 2'd0,
        LOW8     = 2'd1,
        HIGH4    = 2'd2,
        LOW8_ALT = 2'd3
    } pre_sel_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        PLAY     = 2'd1,
        WAIT_ROM = 2'd2
    } chan_state_e;

    // channel sample, zero is silence
    typedef logic signed [6:0] sample_t;
    typedef logic signed [7:0] mix_t;
    typedef logic [16:0]       rom_addr_t;

endpackage

/* hdl/pcm_ctrl_if.sv */
// per-channel control bundle, driven by the register file and read by a channel and the mixer
interface pcm_ctrl_if;

    // sample ROM start address
    pcm_pkg::rom_addr_t rom_start;
    // prescaler preload and length
    logic [11:0]        pre0;
    pcm_pkg::pre_sel_e  pre_sel;
    logic               loop;
    // one clock wide, starts playback
    logic               play;
    logic [3:0]         gain;

    modport src (
        output rom_start, pre0, pre_sel, loop, play, gain
    );

    modport dst (
        input rom_start, pre0, pre_sel, loop, play, gain
    );

endinterface

/* hdl/pcm_regs.sv */
// host register file: byte writes on dacs, play pulses and the E/Q phase strobes
module pcm_regs #(
    // channel A takes the high gain nibble when set
    parameter bit GAIN_A_HIGH = 1'b1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              dacs,
    input  pcm_pkg::reg_idx_e addr,
    input  logic [7:0]        din,
    output logic              cen_e,
    output logic              cen_q,
    pcm_ctrl_if.src           cha,
    pcm_ctrl_if.src           chb
);

    logic [7:0] mmr [0:13];
    logic [1:0] cen_cnt;

    // dacs is both select and write strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 14; i++) begin
                mmr[i] <= '0;
            end
            cha.play <= 1'b0;
            chb.play <= 1'b0;
        end else begin
            // addresses 14 and 15 hold nothing
            if (dacs && addr <= pcm_pkg::LOOP) begin
                mmr[addr] <= din;
            end
            // trigger lands one clock after the write
            cha.play <= dacs && addr == pcm_pkg::CHA_PLAY;
            chb.play <= dacs && addr == pcm_pkg::CHB_PLAY;
        end
    end

    // channel A fields
    assign cha.pre0      = {mmr[pcm_pkg::CHA_PRE_HI][3:0], mmr[pcm_pkg::CHA_PRE_LO]};
    assign cha.pre_sel   = pcm_pkg::pre_sel_e'(mmr[pcm_pkg::CHA_PRE_HI][5:4]);
    assign cha.rom_start = {mmr[pcm_pkg::CHA_ADDR_HI][0], mmr[pcm_pkg::CHA_ADDR_MID],
                            mmr[pcm_pkg::CHA_ADDR_LO]};
    assign cha.loop      = mmr[pcm_pkg::LOOP][0];

    // channel B fields
    assign chb.pre0      = {mmr[pcm_pkg::CHB_PRE_HI][3:0], mmr[pcm_pkg::CHB_PRE_LO]};
    assign chb.pre_sel   = pcm_pkg::pre_sel_e'(mmr[pcm_pkg::CHB_PRE_HI][5:4]);
    assign chb.rom_start = {mmr[pcm_pkg::CHB_ADDR_HI][0], mmr[pcm_pkg::CHB_ADDR_MID],
                            mmr[pcm_pkg::CHB_ADDR_LO]};
    assign chb.loop      = mmr[pcm_pkg::LOOP][1];

    // both gains share register 12, nibble order by parameter
    assign cha.gain = GAIN_A_HIGH ? mmr[pcm_pkg::GAIN][7:4] : mmr[pcm_pkg::GAIN][3:0];
    assign chb.gain = GAIN_A_HIGH ? mmr[pcm_pkg::GAIN][3:0] : mmr[pcm_pkg::GAIN][7:4];

    // quarter-rate strobes in the style of 6809 E/Q
    // Q trails E by two cen pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= 2'd0;
            cen_e   <= 1'b0;
            cen_q   <= 1'b0;
        end else begin
            if (cen) begin
                cen_cnt <= cen_cnt + 2'd1;
            end
            cen_e <= cen && cen_cnt == 2'd3;
            cen_q <= cen && cen_cnt == 2'd1;
        end
    end

    // phases must stay apart
    a_cen_phase : assert property (
        @(posedge clk) disable iff (rst) !(cen_e && cen_q)
    );

    // play strobe never lasts beyond one clock
    a_play_pulse : assert property (
        @(posedge clk) disable iff (rst) cha.play |=> !cha.play
    );

endmodule

/* hdl/pcm_channel.sv */
// one playback channel with prescaler, ROM address walk and end marker, instanced per channel by the top level
module pcm_channel #(
    // subtracted from the ROM byte's low 7 bits
    parameter logic [6:0] SAMPLE_OFFSET = 7'h40
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen_q,
    pcm_ctrl_if.dst            ctrl,
    output pcm_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_dout,
    input  logic               rom_ok,
    output pcm_pkg::sample_t   snd
);

    pcm_pkg::chan_state_e state;
    logic [11:0]          cnt;
    logic [11:0]          cnt_step;
    logic                 over;
    logic                 tick;
    logic                 take;
    pcm_pkg::sample_t     sample;

    // overflow width follows the length select
    always_comb begin
        case (ctrl.pre_sel)
            pcm_pkg::LOW8, pcm_pkg::LOW8_ALT: begin
                over     = &cnt[7:0];
                cnt_step = 12'h001;
            end
            pcm_pkg::HIGH4: begin
                // high nibble counts in its own units
                over     = &cnt[11:8];
                cnt_step = 12'h100;
            end
            default: begin
                over     = &cnt;
                cnt_step = 12'h001;
            end
        endcase
    end

    // one address step per prescaler overflow
    assign tick = cen_q && over;

    // sample accepted on overflow or late once the ROM catches up
    assign take = rom_ok && ((state == pcm_pkg::PLAY && tick) || state == pcm_pkg::WAIT_ROM);

    assign sample = pcm_pkg::sample_t'(rom_dout[6:0] - SAMPLE_OFFSET);

    assign rom_cs = state != pcm_pkg::IDLE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= pcm_pkg::IDLE;
            cnt      <= '0;
            rom_addr <= '0;
            snd      <= '0;
        end else begin
            // prescaler keeps running and reloads on overflow
            if (cen_q) begin
                if (over) begin
                    cnt <= ctrl.pre0;
                end else begin
                    cnt <= cnt + cnt_step;
                end
            end
            if (ctrl.play) begin
                // (re)start from the top even mid-sample
                state    <= pcm_pkg::PLAY;
                rom_addr <= ctrl.rom_start;
                cnt      <= ctrl.pre0;
            end else if (take) begin
                snd      <= sample;
                rom_addr <= rom_addr + 1'b1;
                state    <= pcm_pkg::PLAY;
                // bit 7 marks the last byte
                if (rom_dout[7]) begin
                    if (ctrl.loop) begin
                        rom_addr <= ctrl.rom_start;
                    end else begin
                        state <= pcm_pkg::IDLE;
                        snd   <= '0;
                    end
                end
            end else if (state == pcm_pkg::PLAY && tick) begin
                // data late while the prescaler has already reloaded
                state <= pcm_pkg::WAIT_ROM;
            end
        end
    end

    // output is silent whenever the channel is stopped
    a_idle_silent : assert property (
        @(posedge clk) disable iff (rst) !rom_cs |-> snd == '0
    );

endmodule

/* hdl/pcm_mixer.sv */
// scales both channel samples by their gains and sums them into the registered output
module pcm_mixer (
    input  logic             clk,
    input  logic             rst,
    input  pcm_pkg::sample_t snda,
    input  pcm_pkg::sample_t sndb,
    pcm_ctrl_if.dst          cha,
    pcm_ctrl_if.dst          chb,
    output pcm_pkg::mix_t    snd
);

    // gains are unsigned, widen with a zero sign bit
    logic signed [4:0]  gain_a;
    logic signed [4:0]  gain_b;
    // worst case -64*15 per channel
    logic signed [11:0] prod_a;
    logic signed [11:0] prod_b;
    logic signed [11:0] sum;

    assign gain_a = {1'b0, cha.gain};
    assign gain_b = {1'b0, chb.gain};

    assign prod_a = snda * gain_a;
    assign prod_b = sndb * gain_b;

    // -1920..1890 before the shift
    assign sum = prod_a + prod_b;

    // divide by 16, lands in -120..118 so no clipping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd <= '0;
        end else begin
            snd <= pcm_pkg::mix_t'(sum >>> 4);
        end
    end

endmodule

/* hdl/pcm2ch_top.sv */
// pcm2ch top level, register file feeding two channels and the mixer, plain ports outside
module pcm2ch_top #(
    parameter bit         GAIN_A_HIGH   = 1'b1,
    parameter logic [6:0] SAMPLE_OFFSET = 7'h40
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               dacs,
    input  logic [3:0]         addr,
    input  logic [7:0]         din,
    output logic               cen_e,
    output logic               cen_q,
    // channel A sample ROM
    output pcm_pkg::rom_addr_t roma_addr,
    output logic               roma_cs,
    input  logic [7:0]         roma_dout,
    input  logic               roma_ok,
    // channel B sample ROM
    output pcm_pkg::rom_addr_t romb_addr,
    output logic               romb_cs,
    input  logic [7:0]         romb_dout,
    input  logic               romb_ok,
    // raw channel samples and mix
    output pcm_pkg::sample_t   snda,
    output pcm_pkg::sample_t   sndb,
    output pcm_pkg::mix_t      snd
);

    pcm_ctrl_if cha_ctrl ();
    pcm_ctrl_if chb_ctrl ();

    pcm_regs #(
        .GAIN_A_HIGH (GAIN_A_HIGH)
    ) u_regs (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .dacs  (dacs),
        .addr  (pcm_pkg::reg_idx_e'(addr)),
        .din   (din),
        .cen_e (cen_e),
        .cen_q (cen_q),
        .cha   (cha_ctrl),
        .chb   (chb_ctrl)
    );

    pcm_channel #(
        .SAMPLE_OFFSET (SAMPLE_OFFSET)
    ) u_cha (
        .clk      (clk),
        .rst      (rst),
        .cen_q    (cen_q),
        .ctrl     (cha_ctrl),
        .rom_addr (roma_addr),
        .rom_cs   (roma_cs),
        .rom_dout (roma_dout),
        .rom_ok   (roma_ok),
        .snd      (snda)
    );

    pcm_channel #(
        .SAMPLE_OFFSET (SAMPLE_OFFSET)
    ) u_chb (
        .clk      (clk),
        .rst      (rst),
        .cen_q    (cen_q),
        .ctrl     (chb_ctrl),
        .rom_addr (romb_addr),
        .rom_cs   (romb_cs),
        .rom_dout (romb_dout),
        .rom_ok   (romb_ok),
        .snd      (sndb)
    );

    // gains come straight from the control bundles
    pcm_mixer u_mixer (
        .clk  (clk),
        .rst  (rst),
        .snda (snda),
        .sndb (sndb),
        .cha  (cha_ctrl),
        .chb  (chb_ctrl),
        .snd  (snd)
    );

endmodule

/* verification/pcm2ch_rom_model.sv */
// behavioral sample ROM for the pcm2ch testbench, data and ok one clock after a cs/addr request
module pcm2ch_rom_model (
    input  logic               clk,
    input  logic               rst,
    input  logic               cs,
    input  pcm_pkg::rom_addr_t addr,
    // forces ok low while set
    input  logic               hold,
    output logic [7:0]         dout,
    output logic               ok
);
    timeunit 1ns;
    timeprecision 100ps;

    // only the low address byte selects a location
    logic [7:0]         mem [0:255];
    pcm_pkg::rom_addr_t addr_q;
    logic               ok_q;

    // default fill, each location differs by its index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 37 + 11);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            addr_q <= '0;
            ok_q   <= 1'b0;
        end else begin
            dout   <= mem[addr[7:0]];
            addr_q <= addr;
            ok_q   <= cs && !hold;
        end
    end

    // ok only while dout still belongs to the address on the bus
    assign ok = ok_q && addr_q == addr;

endmodule

/* verification/pcm2ch_tb.sv */
// self-checking testbench that runs pcm2ch_top through a case table and reports the result
module pcm2ch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // one playback case with fields packed in this order
    typedef struct packed {
        logic               chb;
        logic [7:0]         pre_lo;
        logic [7:0]         pre_hi;
        pcm_pkg::rom_addr_t start;
        logic [7:0]         loop_reg;
        logic [31:0]        rom;
        logic [3:0]         ticks;
        logic               stall;
    } case_t;

    logic clk, rst, cen, dacs, hold_a, hold_b;
    logic [3:0] addr;
    logic [7:0] din, roma_dout, romb_dout;
    logic cen_e, cen_q, roma_cs, romb_cs, roma_ok, romb_ok;
    pcm_pkg::rom_addr_t roma_addr, romb_addr;
    pcm_pkg::sample_t snda, sndb, swap_snda, swap_sndb;
    pcm_pkg::mix_t snd, swap_snd;
    int errors = 0;
    int checks = 0;
    case_t cases [5];
    logic [7:0] gains [6];

    pcm2ch_top u_pcm2ch_top (
        .clk (clk), .rst (rst), .cen (cen), .dacs (dacs), .addr (addr), .din (din),
        .cen_e (cen_e), .cen_q (cen_q),
        .roma_addr (roma_addr), .roma_cs (roma_cs), .roma_dout (roma_dout), .roma_ok (roma_ok),
        .romb_addr (romb_addr), .romb_cs (romb_cs), .romb_dout (romb_dout), .romb_ok (romb_ok),
        .snda (snda), .sndb (sndb), .snd (snd)
    );

    // second DUT with swapped gain nibbles shares the ROMs in lockstep
    pcm2ch_top #(.GAIN_A_HIGH (1'b0)) u_pcm2ch_swap (
        .clk (clk), .rst (rst), .cen (cen), .dacs (dacs), .addr (addr), .din (din),
        .cen_e (), .cen_q (),
        .roma_addr (), .roma_cs (), .roma_dout (roma_dout), .roma_ok (roma_ok),
        .romb_addr (), .romb_cs (), .romb_dout (romb_dout), .romb_ok (romb_ok),
        .snda (swap_snda), .sndb (swap_sndb), .snd (swap_snd)
    );

    pcm2ch_rom_model u_roma (
        .clk (clk), .rst (rst), .cs (roma_cs), .addr (roma_addr), .hold (hold_a),
        .dout (roma_dout), .ok (roma_ok)
    );

    pcm2ch_rom_model u_romb (
        .clk (clk), .rst (rst), .cs (romb_cs), .addr (romb_addr), .hold (hold_b),
        .dout (romb_dout), .ok (romb_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_sample(input string name, input pcm_pkg::sample_t got,
                                input pcm_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mix(input string name, input pcm_pkg::mix_t got,
                             input pcm_pkg::mix_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input pcm_pkg::rom_addr_t got,
                              input pcm_pkg::rom_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    // cen_q pulses between two address steps
    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d  checks: %0d", errors + 1, checks);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ROM byte to sample as low 7 bits less 0x40
    function automatic pcm_pkg::sample_t byte_to_sample(input logic [7:0] b);
        int v;
        v = b[6:0];
        return pcm_pkg::sample_t'(v - 64);
    endfunction

    // gain-weighted sum divided by 16 rounding down
    function automatic pcm_pkg::mix_t mix_rule(input pcm_pkg::sample_t sa,
                                               input pcm_pkg::sample_t sb,
                                               input logic [3:0] ga, input logic [3:0] gb);
        int p;
        p = int'(sa) * int'({28'd0, ga}) + int'(sb) * int'({28'd0, gb});
        return pcm_pkg::mix_t'(p >>> 4);
    endfunction

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        dacs = 1'b1;
        addr = a;
        din  = d;
        @(posedge clk);
        #1;
        dacs = 1'b0;
    endtask

    task automatic start_channel(input logic chb, input logic [7:0] pre_lo,
                                 input logic [7:0] pre_hi, input pcm_pkg::rom_addr_t start);
        logic [3:0] base;
        base = chb ? 4'd6 : 4'd0;
        write_reg(base, pre_lo);
        write_reg(base + 4'd1, pre_hi);
        write_reg(base + 4'd2, start[7:0]);
        write_reg(base + 4'd3, start[15:8]);
        write_reg(base + 4'd4, {7'd0, start[16]});
    endtask

    // wait for the next address change and count cen_q pulses
    task automatic wait_step(input logic chb, input pcm_pkg::rom_addr_t prev, output int ticks);
        int n;
        ticks = 0;
        for (n = 0; n < 200; n++) begin
            @(negedge clk);
            if (cen_q) ticks++;
            if ((chb ? romb_addr : roma_addr) != prev) break;
        end
        if (n == 200) stop_on_timeout("an address step");
    endtask

    task automatic run_case(input case_t c);
        pcm_pkg::rom_addr_t prev, exp_addr;
        pcm_pkg::sample_t exp_snd;
        logic exp_cs, lp;
        logic [7:0] b;
        int ticks, n;
        string an, cn, sn;
        an = c.chb ? "romb_addr" : "roma_addr";
        cn = c.chb ? "romb_cs" : "roma_cs";
        sn = c.chb ? "sndb" : "snda";
        lp = c.chb ? c.loop_reg[1] : c.loop_reg[0];
        for (n = 0; n < 4; n++) begin
            if (c.chb) u_romb.mem[8'(c.start[7:0] + n)] = c.rom[8*n +: 8];
            else u_roma.mem[8'(c.start[7:0] + n)] = c.rom[8*n +: 8];
        end
        start_channel(c.chb, c.pre_lo, c.pre_hi, c.start);
        write_reg(pcm_pkg::LOOP, c.loop_reg);
        write_reg(c.chb ? pcm_pkg::CHB_PLAY : pcm_pkg::CHA_PLAY, 8'h00);
        for (n = 0; n < 50; n++) begin
            @(negedge clk);
            if (c.chb ? romb_cs : roma_cs) break;
        end
        if (n == 50) stop_on_timeout("the channel to start");
        check_addr(an, c.chb ? romb_addr : roma_addr, c.start);
        prev = c.start;
        for (n = 0; n < 4; n++) begin
            wait_step(c.chb, prev, ticks);
            b = c.rom[8*n +: 8];
            exp_snd  = byte_to_sample(b);
            exp_addr = c.start + n + 1;
            exp_cs   = 1'b1;
            // end marker goes back to the start or stops silent
            if (b[7]) begin
                if (lp) begin
                    exp_addr = c.start;
                end else begin
                    exp_cs  = 1'b0;
                    exp_snd = '0;
                end
            end
            check_addr(an, c.chb ? romb_addr : roma_addr, exp_addr);
            check_level(cn, c.chb ? romb_cs : roma_cs, exp_cs);
            check_sample(sn, c.chb ? sndb : snda, exp_snd);
            // first interval includes the start latency
            if (c.ticks != 0 && n > 0) check_count("cen_q ticks per step", ticks, c.ticks);
            prev = c.chb ? romb_addr : roma_addr;
            // ROM stalls across the next prescaler overflow
            if (c.stall && n < 2) begin
                @(posedge clk);
                #1;
                if (c.chb) hold_b = 1'b1;
                else hold_a = 1'b1;
                repeat (6) @(posedge clk);
                #1;
                hold_a = 1'b0;
                hold_b = 1'b0;
            end
        end
    endtask

    initial begin
        int n;
        pcm_pkg::sample_t exp_a;
        pcm_pkg::sample_t exp_b;
        rst    = 1'b1;
        cen    = 1'b1;
        dacs   = 1'b0;
        addr   = '0;
        din    = '0;
        hold_a = 1'b0;
        hold_b = 1'b0;
        // one-shot, loop on B, LOW8 and HIGH4 rates, ROM stall
        cases[0] = {1'b0, 8'hFF, 8'h0F, 17'h10310, 8'h00, 32'hC5007F41, 4'd1, 1'b0};
        cases[1] = {1'b1, 8'hFF, 8'h0F, 17'h0A520, 8'h02, 32'hE2453060, 4'd1, 1'b0};
        cases[2] = {1'b0, 8'hFC, 8'h10, 17'h00030, 8'h02, 32'h8C484440, 4'd4, 1'b0};
        cases[3] = {1'b0, 8'h00, 8'h2E, 17'h1FF40, 8'h02, 32'hBF3F3050, 4'd2, 1'b0};
        cases[4] = {1'b0, 8'hFF, 8'h0F, 17'h00050, 8'h02, 32'hB3332211, 4'd0, 1'b1};
        gains = '{8'hF0, 8'h0F, 8'hFF, 8'h3A, 8'h9C, 8'hC5};
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet after reset
        @(negedge clk);
        check_level("cen_e", cen_e, 1'b0);
        check_level("cen_q", cen_q, 1'b0);
        check_level("roma_cs", roma_cs, 1'b0);
        check_level("romb_cs", romb_cs, 1'b0);
        check_mix("snd", snd, '0);
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            if (cen_q) break;
        end
        if (n == 10) stop_on_timeout("the first cen_q pulse");
        // q every fourth clock with e halfway between
        for (n = 1; n <= 8; n++) begin
            @(negedge clk);
            check_level("cen_q", cen_q, n % 4 == 0);
            check_level("cen_e", cen_e, n % 4 == 2);
        end

        foreach (cases[i]) begin
            run_case(cases[i]);
        end

        // constant -64 on A and +63 on B with both looping
        exp_a = byte_to_sample(8'h00);
        exp_b = byte_to_sample(8'h7F);
        for (n = 0; n < 4; n++) begin
            u_roma.mem[8'h60 + n] = (n == 3) ? 8'h80 : 8'h00;
            u_romb.mem[8'h70 + n] = (n == 3) ? 8'hFF : 8'h7F;
        end
        start_channel(1'b0, 8'hFF, 8'h0F, 17'h00060);
        start_channel(1'b1, 8'hFF, 8'h0F, 17'h00070);
        write_reg(pcm_pkg::LOOP, 8'h03);
        write_reg(pcm_pkg::CHA_PLAY, 8'h00);
        write_reg(pcm_pkg::CHB_PLAY, 8'h00);
        for (n = 0; n < 100; n++) begin
            @(negedge clk);
            if (snda == exp_a && sndb == exp_b) break;
        end
        if (n == 100) stop_on_timeout("both mixer inputs");
        foreach (gains[i]) begin
            write_reg(pcm_pkg::GAIN, gains[i]);
            // register then mixer stage
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_sample("swap snda", swap_snda, exp_a);
            check_sample("swap sndb", swap_sndb, exp_b);
            check_mix("snd", snd, mix_rule(exp_a, exp_b, gains[i][7:4], gains[i][3:0]));
            check_mix("swap snd", swap_snd, mix_rule(exp_a, exp_b, gains[i][3:0], gains[i][7:4]));
        end

        $display("errors: %0d  checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* pcm2ch.f */
hdl/pcm_pkg.sv
hdl/pcm_ctrl_if.sv
hdl/pcm_regs.sv
hdl/pcm_channel.sv
hdl/pcm_mixer.sv
hdl/pcm2ch_top.sv
verification/pcm2ch_rom_model.sv
verification/pcm2ch_tb.sv
